// ==== bench/matrix_inv_tb.sv ====
`timescale 1ns/1ps

module matrix_inv_tb import matrix_inv_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_RUNS   = 8;                        // engine runs over all tests
	localparam int RUN_CYCLES = CELLS + 23 + CELLS + 40;  // load, compute, read, margin
	localparam int WATCHDOG   = NUM_RUNS * RUN_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD;

	logic      clk;
	logic      reset;
	logic      load;
	cell_idx_t load_idx;
	word_t     load_data;
	logic      start;
	cell_idx_t read_idx;
	logic      busy;
	logic      done;
	logic      singular;
	word_t     read_data;
	word_t     read_diag;

	word_t       mat_in [CELLS];     // matrix sent to the DUT, row-major
	word_t       exp_right [CELLS];  // expected right half
	word_t       exp_diag [DIM];     // expected final diagonal
	logic [15:0] lfsr;               // random source

	matrix_inv_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG);
		stop_with_error($sformatf("watchdog: tests still running after %0d ns", WATCHDOG));
	end

	////////////////////////////////////////////////////////////////////////////
	// checking and stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED time %0t: %s expected %0d (0x%08h) got %0d (0x%08h)", $time, name,
				$signed(expected), expected, $signed(actual), actual);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// x^16 + x^14 + x^13 + x^11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_word(input int bits);
		word_t w;
		w = '0;
		for (int i = 0; i < bits; i++)
			w = {w[WORD_W-2:0], lfsr_bit()};  // one step per bit
		if (bits < WORD_W && w[bits-1])
			w = w | (~word_t'(0) << bits);     // sign extend short words
		return w;
	endfunction

	// gauss-jordan by cross multiplication with 32 bit wrap
	function automatic void model_eliminate();
		word_t aug [DIM][AUG_COLS];
		word_t nrow [AUG_COLS];
		word_t p;
		word_t f;
		for (int r = 0; r < DIM; r++)
			for (int c = 0; c < AUG_COLS; c++)
				aug[r][c] = (c < DIM) ? mat_in[r*DIM + c] : word_t'(c - DIM == r);
		for (int k = 0; k < DIM; k++)
			for (int r = 0; r < DIM; r++)
				if (r != k)
				begin
					p = aug[k][k];  // pivot
					f = aug[r][k];  // value to cancel
					for (int c = 0; c < AUG_COLS; c++)
						nrow[c] = p * aug[r][c] - f * aug[k][c];
					aug[r] = nrow;
				end
		for (int r = 0; r < DIM; r++)
		begin
			exp_diag[r] = aug[r][r];
			for (int c = 0; c < DIM; c++)
				exp_right[r*DIM + c] = aug[r][DIM + c];
		end
	endfunction

	task automatic load_matrix();
		for (int i = 0; i < CELLS; i++)
		begin
			@(negedge clk);
			load      = 1'b1;
			load_idx  = cell_idx_t'(i);
			load_data = mat_in[i];
		end
		@(negedge clk);
		load = 1'b0;
	endtask

	// pulse start and count the edges up to done with an optional load and start while busy
	task automatic run_engine(input bit poke_busy);
		int edges;
		edges = 0;
		start = 1'b1;
		@(negedge clk);  // start sampled at the edge just passed
		start = 1'b0;
		do
		begin
			@(negedge clk);
			start = 1'b0;
			load  = 1'b0;
			edges++;
			if (poke_busy && edges == 6)
			begin
				check("busy", 32'd1, {31'd0, busy});
				load      = 1'b1;          // must be dropped
				load_idx  = cell_idx_t'(7);
				load_data = 32'h7fff_0001;
				start     = 1'b1;          // must be dropped too
			end
			if (edges > 60)
				stop_with_error("done did not rise within 60 clock edges of start");
		end
		while (!done);
		check("done edges after start", 32'd23, edges);
		check("busy", 32'd0, {31'd0, busy});
		@(negedge clk);
		check("done", 32'd0, {31'd0, done});  // single cycle pulse
	endtask

	task automatic read_results();
		logic exp_sing;
		exp_sing = 1'b0;
		for (int r = 0; r < DIM; r++)
			if (exp_diag[r] == 0)
				exp_sing = 1'b1;
		check("singular", {31'd0, exp_sing}, {31'd0, singular});
		for (int i = 0; i < CELLS; i++)
		begin
			@(negedge clk);
			read_idx = cell_idx_t'(i);
			@(posedge clk);
			check($sformatf("read_data[%0d]", i), exp_right[i], read_data);
			check($sformatf("read_diag[%0d]", i), exp_diag[i / DIM], read_diag);
		end
	endtask

	task automatic solve_and_check(input bit poke_busy);
		load_matrix();
		run_engine(poke_busy);
		read_results();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic invert_identity();
		for (int i = 0; i < CELLS; i++)
		begin
			mat_in[i]    = (i / DIM == i % DIM) ? 1 : 0;
			exp_right[i] = mat_in[i];  // inverse of I is I
		end
		for (int r = 0; r < DIM; r++)
			exp_diag[r] = 1;
		solve_and_check(1'b0);
	endtask

	// L*U with unit factors, det 1, so every pivot stays 1
	task automatic invert_unimodular();
		word_t inv_known [CELLS];
		mat_in = '{1, -1,  0,  0,  0,
		           1,  0, -1,  0,  0,
		           0,  1,  0, -1,  0,
		           0,  0,  1,  0, -1,
		           0,  0,  0,  1,  0};
		inv_known = '{1,  0,  1,  0,  1,
		              0,  0,  1,  0,  1,
		              1, -1,  1,  0,  1,
		              0,  0,  0,  0,  1,
		              1, -1,  1, -1,  1};
		model_eliminate();
		solve_and_check(1'b0);
		for (int i = 0; i < CELLS; i++)
		begin
			@(negedge clk);
			read_idx = cell_idx_t'(i);
			@(posedge clk);
			if (read_diag == 0)
				stop_with_error($sformatf("zero diagonal for cell %0d of an invertible matrix", i));
			check($sformatf("read_data/read_diag[%0d]", i), inv_known[i], read_data / read_diag);
			check($sformatf("read_data%%read_diag[%0d]", i), 32'd0, read_data % read_diag);
		end
	endtask

	task automatic flag_singular();
		mat_in = '{2, 1, 0, 3, 1,
		           1, 4, 2, 0, 5,
		           2, 1, 0, 3, 1,    // same as row 0
		           0, 2, 1, 1, 3,
		           3, 0, 1, 2, 4};
		model_eliminate();
		if (exp_diag[2] != 0)
			stop_with_error("model gave no zero diagonal for a matrix with equal rows");
		solve_and_check(1'b0);
	endtask

	task automatic compare_random();
		for (int t = 0; t < 3; t++)
		begin
			for (int i = 0; i < CELLS; i++)
				mat_in[i] = rand_word((t == 2) ? 8 : WORD_W);  // last one small signed
			model_eliminate();
			solve_and_check(1'b0);
		end
	endtask

	task automatic ignore_while_busy();
		for (int i = 0; i < CELLS; i++)
			mat_in[i] = rand_word(12);
		model_eliminate();
		solve_and_check(1'b1);  // commands while busy
		solve_and_check(1'b0);  // same matrix again
	endtask

	initial
	begin
		reset     = 1'b0;
		load      = 1'b0;
		load_idx  = '0;
		load_data = '0;
		start     = 1'b0;
		read_idx  = '0;
		lfsr      = 16'd65302;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		check("busy", 32'd0, {31'd0, busy});
		check("done", 32'd0, {31'd0, done});
		check("singular", 32'd0, {31'd0, singular});
		check("read_data", 32'd0, read_data);  // cells cleared by reset
		invert_identity();
		invert_unimodular();
		flag_singular();
		compare_random();
		ignore_while_busy();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== matrix_inv.f ====
verilog/matrix_inv_pkg.sv
verilog/load_decode.sv
verilog/elim_engine.sv
verilog/result_select.sv
verilog/matrix_inv_top.sv
bench/matrix_inv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module matrix_inv_tb \
	-f matrix_inv.f -o matrix_inv_sim &&
./obj_dir/matrix_inv_sim | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verilog/elim_engine.sv ====
`timescale 1ns/1ps

module elim_engine import matrix_inv_pkg::*; (
	input  logic               clk,
	input  logic               reset,       // sync, active low
	input  cell_wr_t           cell_wr,     // left half writes from the host
	input  logic               go,          // start command
	output logic               busy,        // row operations in progress
	output logic               finish,      // one cycle at the end of a run
	output diag_vec_t          diag,        // left half diagonal
	output aug_row_t [DIM-1:0] right_half   // all rows, read side picks columns
);

	aug_row_t [DIM-1:0] mat;      // augmented matrix storage
	aug_row_t [DIM-1:0] eff;      // rows as the current operation sees them
	aug_row_t           piv_row;  // row k
	aug_row_t           src_row;  // row r
	aug_row_t           new_row;  // result for row r
	word_t              p_val;    // pivot value
	word_t              f_val;    // row r value in column k

	logic               armed;      // go seen, first operation next edge
	logic [POS_W-1:0]   pivot;      // k
	logic [POS_W-1:0]   row;        // r, never equal to k
	logic [POS_W-1:0]   nxt_pivot;
	logic [POS_W-1:0]   nxt_row;
	logic [IDX_W-1:0]   op_cnt;     // operations done this run
	logic               op_en;      // an operation happens at this edge
	logic               last_op;    // operation 19 of 0..19

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	// on the first operation the right half is seen as the identity
	always_comb
	begin
		for (int i = 0; i < DIM; i++)
		begin
			eff[i] = mat[i];
			if (armed)
			begin
				for (int j = 0; j < DIM; j++)
				begin
					eff[i][DIM+j] = (i == j) ? word_t'(1) : word_t'(0);
				end
			end
		end
	end

	assign piv_row = eff[pivot];
	assign src_row = eff[row];
	assign p_val   = piv_row[pivot];  // diagonal element of row k
	assign f_val   = src_row[pivot];  // element to cancel

	// cross multiply so column k of row r cancels without a divide
	always_comb
	begin
		for (int c = 0; c < AUG_COLS; c++)
		begin
			new_row[c] = p_val * src_row[c] - f_val * piv_row[c];  // low 32 bits kept
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencing
	////////////////////////////////////////////////////////////////////////////

	assign op_en   = armed | (busy & (op_cnt < cell_idx_t'(ROW_OPS)));
	assign last_op = (op_cnt == cell_idx_t'(ROW_OPS - 1));

	// next row in ascending order skipping the pivot row
	always_comb
	begin
		nxt_pivot = pivot;
		nxt_row   = row + 3'd1;
		if (nxt_row == pivot)
		begin
			nxt_row = nxt_row + 3'd1;  // step over row k
		end
		if (nxt_row >= POS_W'(DIM))
		begin
			nxt_pivot = pivot + 3'd1;  // rows used up so move the pivot
			nxt_row   = '0;            // next pivot is at least 1
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			armed  <= 1'b0;
			busy   <= 1'b0;
			finish <= 1'b0;
			pivot  <= '0;
			row    <= '0;
			op_cnt <= '0;
			mat    <= '0;  // all cells zero after reset
		end
		else
		begin
			finish <= 1'b0;
			if (go)
			begin
				armed  <= 1'b1;
				pivot  <= '0;
				row    <= 3'd1;  // first row below pivot 0
				op_cnt <= '0;
			end
			if (armed)
			begin
				armed <= 1'b0;
				busy  <= 1'b1;
			end
			if (op_en)
			begin
				op_cnt <= op_cnt + 5'd1;
				if (!last_op)
				begin
					pivot <= nxt_pivot;  // counters park on the last pair
					row   <= nxt_row;
				end
			end
			else if (busy)
			begin
				busy   <= 1'b0;  // all 20 operations written
				finish <= 1'b1;
			end

			// matrix update
			if (op_en)
			begin
				for (int i = 0; i < DIM; i++)
				begin
					if (i == int'(row))
					begin
						mat[i] <= new_row;
					end
					else if (armed)
					begin
						mat[i] <= eff[i];  // identity seeded into the right half
					end
				end
			end
			else if (cell_wr.valid && !busy)
			begin
				mat[cell_wr.pos.row][cell_wr.pos.col] <= cell_wr.data;  // host load
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < DIM; i++)
		begin
			diag[i] = mat[i][i];  // scale of each inverse row
		end
	end

	assign right_half = mat;

	// counters stay inside the matrix for the whole run
	a_pivot_range: assert property (@(posedge clk) disable iff (!reset)
		busy |-> (pivot <= POS_W'(DIM - 1)))
		else $error("elim_engine: pivot %0d past the last row", pivot);

	// load_decode holds start off until the run is over
	a_go_idle: assert property (@(posedge clk) disable iff (!reset)
		go |-> !(busy || armed))
		else $error("elim_engine: go while a run is in progress");

endmodule

// ==== verilog/load_decode.sv ====
`timescale 1ns/1ps

module load_decode import matrix_inv_pkg::*; (
	input  logic      clk,
	input  logic      reset,      // sync, active low
	input  logic      load,       // host write strobe
	input  cell_idx_t load_idx,   // row-major cell number
	input  word_t     load_data,
	input  logic      start,      // host start pulse
	input  logic      busy,       // engine running
	output cell_wr_t  cell_wr,    // registered cell write
	output logic      go          // one cycle start command
);

	logic      go_d;    // go one cycle later
	logic      hold;    // engine running or about to run
	logic      idx_ok;  // index inside the matrix
	logic      take;    // load accepted at this edge
	cell_pos_t pos;

	assign idx_ok = (load_idx < cell_idx_t'(CELLS));
	assign pos    = split_idx(load_idx);

	// busy only rises two edges after go so those edges are covered here
	assign hold = busy | go | go_d;
	assign take = load & idx_ok & ~hold;

	////////////////////////////////////////////////////////////////////////////
	// command registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			cell_wr.valid <= 1'b0;
			go            <= 1'b0;
			go_d          <= 1'b0;
		end
		else
		begin
			cell_wr.valid <= take;           // dropped when out of range or busy
			go            <= start & ~hold;  // ignored while busy
			go_d          <= go;
			if (take)
			begin
				cell_wr.pos  <= pos;           // row and column of the write
				cell_wr.data <= load_data;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// the host only addresses cells 0 to 24
	a_load_idx: assert property (@(posedge clk) disable iff (!reset)
		load |-> (load_idx < cell_idx_t'(CELLS)))
		else $error("load_decode: load_idx %0d outside the matrix", load_idx);

endmodule

// ==== verilog/matrix_inv_pkg.sv ====
package matrix_inv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// matrix sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int DIM      = 5;                // matrix order
	localparam int WORD_W   = 32;               // cell width
	localparam int CELLS    = DIM * DIM;        // cells written by the host
	localparam int AUG_COLS = 2 * DIM;          // loaded half plus identity half
	localparam int ROW_OPS  = DIM * (DIM - 1);  // row operations per run
	localparam int IDX_W    = 5;                // bits in a cell index
	localparam int POS_W    = 3;                // bits in a row or column number

	typedef logic signed [WORD_W-1:0] word_t;   // one matrix cell
	typedef logic [IDX_W-1:0] cell_idx_t;       // row-major cell number

	typedef struct packed {
		logic [POS_W-1:0] row;
		logic [POS_W-1:0] col;
	} cell_pos_t;

	typedef struct packed {
		logic      valid;  // write strobe
		cell_pos_t pos;    // target cell in the left half
		word_t     data;
	} cell_wr_t;

	typedef word_t [AUG_COLS-1:0] aug_row_t;    // columns DIM and up are the right half
	typedef word_t [DIM-1:0] diag_vec_t;        // left half diagonal after elimination

	// row-major index to row and column by stepping down whole rows
	function automatic cell_pos_t split_idx(input cell_idx_t idx);
		cell_pos_t pos;
		cell_idx_t rem;
		pos.row = '0;
		rem = idx;
		for (int i = 1; i < DIM; i++)
		begin
			if (rem >= cell_idx_t'(DIM))
			begin
				rem = rem - cell_idx_t'(DIM);  // one row further down
				pos.row = pos.row + 3'd1;
			end
		end
		pos.col = rem[POS_W-1:0];  // what is left is the column
		return pos;
	endfunction

endpackage

// ==== verilog/matrix_inv_top.sv ====
`timescale 1ns/1ps

module matrix_inv_top import matrix_inv_pkg::*; (
	input  logic      clk,
	input  logic      reset,      // sync, active low
	input  logic      load,       // cell write strobe
	input  cell_idx_t load_idx,
	input  word_t     load_data,
	input  logic      start,      // start pulse
	input  cell_idx_t read_idx,
	output logic      busy,
	output logic      done,
	output logic      singular,
	output word_t     read_data,
	output word_t     read_diag
);

	cell_wr_t           cell_wr;     // decoded host write
	logic               go;          // registered start
	logic               finish;      // end of elimination
	diag_vec_t          diag;
	aug_row_t [DIM-1:0] right_half;  // engine storage to the read port

	////////////////////////////////////////////////////////////////////////////
	// decode, execute, result
	////////////////////////////////////////////////////////////////////////////

	load_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.load_idx  (load_idx),
		.load_data (load_data),
		.start     (start),
		.busy      (busy),
		.cell_wr   (cell_wr),
		.go        (go)
	);

	elim_engine u_engine (
		.clk        (clk),
		.reset      (reset),
		.cell_wr    (cell_wr),
		.go         (go),
		.busy       (busy),
		.finish     (finish),
		.diag       (diag),
		.right_half (right_half)
	);

	result_select u_result (
		.clk        (clk),
		.reset      (reset),
		.finish     (finish),
		.go         (go),
		.diag       (diag),
		.right_half (right_half),
		.read_idx   (read_idx),
		.done       (done),
		.singular   (singular),
		.read_data  (read_data),
		.read_diag  (read_diag)
	);

endmodule

// ==== verilog/result_select.sv ====
`timescale 1ns/1ps

module result_select import matrix_inv_pkg::*; (
	input  logic               clk,
	input  logic               reset,       // sync, active low
	input  logic               finish,      // engine end of run
	input  logic               go,          // new run starting
	input  diag_vec_t          diag,
	input  aug_row_t [DIM-1:0] right_half,
	input  cell_idx_t          read_idx,    // row-major index into the right half
	output logic               done,        // one cycle after finish
	output logic               singular,    // some diagonal is zero
	output word_t              read_data,   // scaled inverse element
	output word_t              read_diag    // divisor for read_data
);

	cell_pos_t rd_pos;    // decoded read index
	logic      rd_ok;     // read index inside the matrix
	logic      any_zero;  // zero on the diagonal

	assign rd_pos = split_idx(read_idx);
	assign rd_ok  = (read_idx < cell_idx_t'(CELLS));

	always_comb
	begin
		any_zero = 1'b0;
		for (int i = 0; i < DIM; i++)
		begin
			if (diag[i] == '0)
			begin
				any_zero = 1'b1;  // no inverse exists
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// status
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			done     <= 1'b0;
			singular <= 1'b0;
		end
		else
		begin
			done <= finish;  // pulse
			if (go)
			begin
				singular <= 1'b0;  // stale flag goes with the new run
			end
			else if (finish)
			begin
				singular <= any_zero;
			end
		end
	end

	// read port, valid while the engine is idle
	always_comb
	begin
		read_data = '0;
		read_diag = '0;
		if (rd_ok)
		begin
			read_data = right_half[rd_pos.row][DIM + int'(rd_pos.col)];
			read_diag = diag[rd_pos.row];  // same row as the cell
		end
	end

endmodule
